/* src/user_io_pkg.sv */
// User IO shared definitions
`default_nettype none

package user_io_pkg;

	// one SPI byte
	typedef logic [7:0] byte_t;
	// byte position inside a transfer, saturates at 255
	typedef logic [7:0] byte_idx_t;
	// config RAM address, same as the SPI byte count, saturates at 1023
	typedef logic [9:0] conf_addr_t;
	// bit position inside a byte
	typedef logic [2:0] bit_idx_t;
	// button mask of one digital joystick
	typedef logic [31:0] joystick_t;
	// core status word
	typedef logic [63:0] status_t;
	// signed mouse delta, sign bit included
	typedef logic [8:0] mouse_axis_t;
	// wheel delta
	typedef logic [3:0] mouse_wheel_t;

	// reply during the command byte, 8 bit core without direct upload
	localparam byte_t CORE_TYPE = 8'hA4;
	// digital joysticks on commands 0x60 up to 0x64
	localparam int JOY_COUNT = 5;

	// command codes sent by the IO controller
	localparam byte_t CMD_BUT_SW = 8'h01;
	localparam byte_t CMD_KBD = 8'h05;
	localparam byte_t CMD_CONF_STR = 8'h14;
	localparam byte_t CMD_STATUS = 8'h15;
	localparam byte_t CMD_STATUS64 = 8'h1E;
	localparam byte_t CMD_JOY_BASE = 8'h60;
	localparam byte_t CMD_MOUSE0 = 8'h70;
	localparam byte_t CMD_MOUSE1 = 8'h71;

	// scan code prefixes inside a keyboard transfer
	localparam byte_t KEY_EXT_PREFIX = 8'hE0;
	localparam byte_t KEY_BREAK_PREFIX = 8'hF0;

endpackage

`default_nettype wire

/* src/spi_link_if.sv */
// SPI domain link
`default_nettype none

interface spi_link_if;
	import user_io_pkg::*;

	// bit position of the byte in flight
	bit_idx_t bit_cnt;
	// completed bytes in this transfer
	conf_addr_t byte_cnt;
	// command that applies to the byte now completing
	byte_t cur_cmd;
	// last complete byte
	byte_t rx_byte;
	// flips once per completed byte
	logic rx_toggle;
	// low while deselected
	logic xfer_active;

	modport source (output bit_cnt, byte_cnt, cur_cmd, rx_byte, rx_toggle, xfer_active);
	modport reply (input bit_cnt, cur_cmd);
	modport sync (input rx_byte, rx_toggle, xfer_active);

endinterface

`default_nettype wire

/* src/cmd_byte_if.sv */
// Command byte bus
`default_nettype none

interface cmd_byte_if;
	import user_io_pkg::*;

	// one cycle pulse per payload byte
	logic valid;
	// command of the running transfer
	byte_t cmd;
	// payload position, 1 for the first payload byte
	byte_idx_t idx;
	byte_t data;
	// synchronized deselect level
	logic xfer_end;

	modport producer (output valid, cmd, idx, data, xfer_end);
	modport consumer (input valid, cmd, idx, data, xfer_end);

endinterface

`default_nettype wire

/* src/spi_byte_receiver.sv */
// SPI byte receiver
`default_nettype none

module spi_byte_receiver (
	input  logic                    SPI_CLK,
	input  logic                    SPI_SS_IO,
	input  logic                    SPI_MOSI,
	spi_link_if.source              link,
	output user_io_pkg::conf_addr_t conf_addr
);
	import user_io_pkg::*;

	// first seven bits of the byte in flight, msb first
	logic [6:0] sbuf;
	// command taken from byte 0
	byte_t cmd_q;
	// full byte including the bit on MOSI now
	byte_t assembled;
	// byte strobe toggle for the clk_sys side
	logic toggle_q = 1'b0;

	assign assembled = {sbuf, SPI_MOSI};

	// bit and byte counters, shift buffer and command latch
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			link.bit_cnt <= '0;
			link.byte_cnt <= '0;
			link.xfer_active <= 1'b0;
			sbuf <= '0;
			cmd_q <= '0;
		end else begin
			link.bit_cnt <= link.bit_cnt + 3'd1;
			link.xfer_active <= 1'b1;
			if (link.bit_cnt == 3'd7) begin
				// byte count saturates at the top of the config RAM
				if (~&link.byte_cnt)
					link.byte_cnt <= link.byte_cnt + 10'd1;
				if (link.byte_cnt == '0)
					cmd_q <= assembled;
			end else begin
				sbuf <= {sbuf[5:0], SPI_MOSI};
			end
		end
	end

	// hand over each complete byte
	always_ff @(posedge SPI_CLK) begin
		if (link.bit_cnt == 3'd7) begin
			link.rx_byte <= assembled;
			toggle_q <= ~toggle_q;
		end
	end

	assign link.rx_toggle = toggle_q;
	// command byte still assembling, so it decides its own reply
	assign link.cur_cmd = (link.byte_cnt == '0) ? assembled : cmd_q;
	assign conf_addr = link.byte_cnt;

endmodule

`default_nettype wire

/* src/spi_reply_shifter.sv */
// SPI reply shifter
`default_nettype none

module spi_reply_shifter (
	input  logic               SPI_CLK,
	input  logic               SPI_SS_IO,
	spi_link_if.reply          link,
	input  user_io_pkg::byte_t conf_chr,
	output logic               SPI_MISO
);
	import user_io_pkg::*;

	// byte going out during the next SPI byte
	byte_t byte_out;

	// reload at the last bit of every byte
	// conf_chr is read while conf_addr still points at the finishing byte
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			byte_out <= CORE_TYPE;
		end else if (link.bit_cnt == 3'd7) begin
			if (link.cur_cmd == CMD_CONF_STR)
				byte_out <= conf_chr;
			else
				byte_out <= '0;
		end
	end

	// bits leave msb first on falling edges
	// bit 7 of the core type appears on the first falling edge,
	// so SPI_CLK idles high between transfers
	always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			SPI_MISO <= 1'b0;
		else
			SPI_MISO <= byte_out[~link.bit_cnt];
	end

endmodule

`default_nettype wire

/* src/cmd_byte_sequencer.sv */
// SPI to clk_sys byte sequencer
`default_nettype none

module cmd_byte_sequencer (
	input  logic          clk_sys,
	spi_link_if.sync      link,
	cmd_byte_if.producer  bus
);
	import user_io_pkg::*;

	// toggle synchronizer plus one stage for edge detect
	logic [2:0] tog_sync;
	// deselect synchronizer
	logic [1:0] end_sync;
	// new byte seen on the clk_sys side
	logic tog_edge;
	// byte position in the running transfer
	byte_idx_t idx_cnt;

	always_ff @(posedge clk_sys) begin
		tog_sync <= {tog_sync[1:0], link.rx_toggle};
		end_sync <= {end_sync[0], ~link.xfer_active};
	end

	assign tog_edge = tog_sync[2] ^ tog_sync[1];
	assign bus.xfer_end = end_sync[1];

	// rx_byte has been stable for two clk_sys cycles once the edge shows
	always_ff @(posedge clk_sys) begin
		bus.valid <= 1'b0;
		if (bus.xfer_end) begin
			idx_cnt <= '0;
		end else if (tog_edge) begin
			if (idx_cnt != 8'hFF)
				idx_cnt <= idx_cnt + 8'd1;
			if (idx_cnt == '0) begin
				// command byte only selects the decoder
				bus.cmd <= link.rx_byte;
			end else begin
				bus.valid <= 1'b1;
				bus.idx <= idx_cnt;
				bus.data <= link.rx_byte;
			end
		end
	end

endmodule

`default_nettype wire

/* src/control_registers.sv */
// Button, joystick and status registers
`default_nettype none

module control_registers (
	input  logic                   clk_sys,
	cmd_byte_if.consumer           bus,
	output user_io_pkg::joystick_t joystick_0,
	output user_io_pkg::joystick_t joystick_1,
	output user_io_pkg::joystick_t joystick_2,
	output user_io_pkg::joystick_t joystick_3,
	output user_io_pkg::joystick_t joystick_4,
	output logic [1:0]             buttons,
	output logic [1:0]             switches,
	output logic                   scandoubler_disable,
	output logic                   ypbpr,
	output logic                   no_csync,
	output user_io_pkg::status_t   status
);
	import user_io_pkg::*;

	// raw button and switch byte
	byte_t but_sw;
	joystick_t joy [JOY_COUNT];
	// byte lane written, payload byte 1 is lane 0
	byte_idx_t lane;
	// joystick number from the command low bits
	logic [2:0] joy_sel;
	logic joy_cmd;

	assign lane = bus.idx - 8'd1;
	assign joy_sel = bus.cmd[2:0];
	assign joy_cmd = (bus.cmd >= CMD_JOY_BASE) && (bus.cmd < CMD_JOY_BASE + JOY_COUNT);

	always_ff @(posedge clk_sys) begin
		if (bus.valid) begin
			case (bus.cmd)
				CMD_BUT_SW: but_sw <= bus.data;
				// short status zero extends into the full word
				CMD_STATUS: status <= {56'd0, bus.data};
				CMD_STATUS64: begin
					if (bus.idx < 8'd9)
						status[{lane[2:0], 3'b000} +: 8] <= bus.data;
				end
				default: begin
					// four little endian bytes, later ones dropped
					if (joy_cmd && bus.idx < 8'd5)
						joy[joy_sel][{lane[1:0], 3'b000} +: 8] <= bus.data;
				end
			endcase
		end
	end

	assign buttons = but_sw[1:0];
	assign switches = but_sw[3:2];
	// video flags
	assign scandoubler_disable = but_sw[4];
	assign ypbpr = but_sw[5];
	assign no_csync = but_sw[6];

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];
	assign joystick_4 = joy[4];

endmodule

`default_nettype wire

/* src/input_event_decoder.sv */
// Keyboard and mouse event decoder
`default_nettype none

module input_event_decoder (
	input  logic                      clk_sys,
	cmd_byte_if.consumer              bus,
	output logic                      key_pressed,
	output logic                      key_extended,
	output user_io_pkg::byte_t        key_code,
	output logic                      key_strobe,
	output user_io_pkg::mouse_axis_t  mouse_x,
	output user_io_pkg::mouse_axis_t  mouse_y,
	output user_io_pkg::mouse_wheel_t mouse_z,
	output user_io_pkg::byte_t        mouse_flags,
	output logic                      mouse_idx,
	output logic                      mouse_strobe
);
	import user_io_pkg::*;

	// prefixes seen earlier in this keyboard transfer
	logic ext_seen;
	logic brk_seen;
	// mouse packet bytes waiting for the wheel byte
	byte_t flags_r;
	byte_t x_r;
	byte_t y_r;
	logic kbd_byte;
	logic mouse_byte;
	logic first;

	assign kbd_byte = bus.valid && !bus.xfer_end && (bus.cmd == CMD_KBD);
	assign mouse_byte = bus.valid && !bus.xfer_end &&
		((bus.cmd == CMD_MOUSE0) || (bus.cmd == CMD_MOUSE1));
	assign first = (bus.idx == 8'd1);

	always_ff @(posedge clk_sys) begin
		key_strobe <= 1'b0;
		mouse_strobe <= 1'b0;

		if (kbd_byte) begin
			// prefix state restarts with each transfer
			if (first) begin
				ext_seen <= 1'b0;
				brk_seen <= 1'b0;
			end
			if (bus.data == KEY_EXT_PREFIX) begin
				ext_seen <= 1'b1;
			end else if (bus.data == KEY_BREAK_PREFIX) begin
				brk_seen <= 1'b1;
			end else begin
				// stale prefixes from an older transfer do not count on byte 1
				key_code <= bus.data;
				key_extended <= ext_seen && !first;
				key_pressed <= !(brk_seen && !first);
				key_strobe <= 1'b1;
			end
		end

		if (mouse_byte) begin
			case (bus.idx)
				8'd1: flags_r <= bus.data;
				8'd2: x_r <= bus.data;
				8'd3: y_r <= bus.data;
				8'd4: begin
					// flags 4 and 5 carry the sign of X and Y
					mouse_flags <= flags_r;
					mouse_x <= {flags_r[4], x_r};
					mouse_y <= {flags_r[5], y_r};
					mouse_z <= bus.data[3:0];
					mouse_idx <= bus.cmd[0];
					mouse_strobe <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/user_io.sv */
// User IO top level
`default_nettype none

module user_io (
	input  logic                      clk_sys,
	input  logic                      SPI_CLK,
	input  logic                      SPI_SS_IO,
	input  logic                      SPI_MOSI,
	output logic                      SPI_MISO,
	output user_io_pkg::conf_addr_t   conf_addr,
	input  user_io_pkg::byte_t        conf_chr,
	output user_io_pkg::joystick_t    joystick_0,
	output user_io_pkg::joystick_t    joystick_1,
	output user_io_pkg::joystick_t    joystick_2,
	output user_io_pkg::joystick_t    joystick_3,
	output user_io_pkg::joystick_t    joystick_4,
	output logic [1:0]                buttons,
	output logic [1:0]                switches,
	output logic                      scandoubler_disable,
	output logic                      ypbpr,
	output logic                      no_csync,
	output user_io_pkg::status_t      status,
	output logic                      key_pressed,
	output logic                      key_extended,
	output user_io_pkg::byte_t        key_code,
	output logic                      key_strobe,
	output user_io_pkg::mouse_axis_t  mouse_x,
	output user_io_pkg::mouse_axis_t  mouse_y,
	output user_io_pkg::mouse_wheel_t mouse_z,
	output user_io_pkg::byte_t        mouse_flags,
	output logic                      mouse_idx,
	output logic                      mouse_strobe
);

	// SPI clock domain signals
	spi_link_if link ();
	// clk_sys domain byte stream
	cmd_byte_if bus ();

	spi_byte_receiver u_rx (
		.SPI_CLK   (SPI_CLK),
		.SPI_SS_IO (SPI_SS_IO),
		.SPI_MOSI  (SPI_MOSI),
		.link      (link),
		.conf_addr (conf_addr)
	);

	spi_reply_shifter u_tx (
		.SPI_CLK   (SPI_CLK),
		.SPI_SS_IO (SPI_SS_IO),
		.link      (link),
		.conf_chr  (conf_chr),
		.SPI_MISO  (SPI_MISO)
	);

	cmd_byte_sequencer u_seq (
		.clk_sys (clk_sys),
		.link    (link),
		.bus     (bus)
	);

	control_registers u_regs (
		.clk_sys             (clk_sys),
		.bus                 (bus),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.joystick_2          (joystick_2),
		.joystick_3          (joystick_3),
		.joystick_4          (joystick_4),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.ypbpr               (ypbpr),
		.no_csync            (no_csync),
		.status              (status)
	);

	input_event_decoder u_events (
		.clk_sys      (clk_sys),
		.bus          (bus),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.key_strobe   (key_strobe),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_z      (mouse_z),
		.mouse_flags  (mouse_flags),
		.mouse_idx    (mouse_idx),
		.mouse_strobe (mouse_strobe)
	);

endmodule

`default_nettype wire

/* tests/user_io_properties.sv */
// Strobe and MISO properties
`default_nettype none

module user_io_properties (
	input logic clk_sys,
	input logic spi_ss_io,
	input logic spi_miso,
	input logic key_strobe,
	input logic mouse_strobe,
	input logic xfer_end
);

	// event strobes are single cycle pulses
	key_strobe_single: assert property (@(posedge clk_sys) key_strobe |=> !key_strobe)
		else $error("key_strobe high for two cycles");

	mouse_strobe_single: assert property (@(posedge clk_sys) mouse_strobe |=> !mouse_strobe)
		else $error("mouse_strobe high for two cycles");

	// no events once the transfer has ended
	strobes_idle_after_end: assert property (@(posedge clk_sys)
		xfer_end |-> !(key_strobe || mouse_strobe))
		else $error("event strobe while xfer_end is high");

	// MISO parked low while deselected
	miso_low_deselected: assert property (@(posedge clk_sys) spi_ss_io |-> !spi_miso)
		else $error("SPI_MISO high while SPI_SS_IO is high");

endmodule

bind user_io user_io_properties u_props (
	.clk_sys      (clk_sys),
	.spi_ss_io    (SPI_SS_IO),
	.spi_miso     (SPI_MISO),
	.key_strobe   (key_strobe),
	.mouse_strobe (mouse_strobe),
	.xfer_end     (bus.xfer_end)
);

`default_nettype wire

/* tests/tb_user_io.sv */
// User IO testbench
`default_nettype none

module tb_user_io;
	import user_io_pkg::*;

	// SPI half period in clk_sys cycles
	localparam int HALF_SPI = 3;
	// idle cycles between transfers
	localparam int GAP = 8;
	localparam int MAX_BYTES = 10;
	localparam int ROUNDS = 2;
	// fifteen transfers per round
	localparam int N_FRAMES = ROUNDS * 15;
	// longest transfer from select to the end of its gap
	localparam int FRAME_CYCLES = HALF_SPI + MAX_BYTES * 16 * HALF_SPI + GAP;
	localparam int TIMEOUT = (N_FRAMES * FRAME_CYCLES + 100) * 10;

	logic clk_sys;
	logic spi_clk;
	logic spi_ss_io;
	logic spi_mosi;
	logic spi_miso;
	conf_addr_t conf_addr;
	byte_t conf_chr;
	joystick_t joystick_0, joystick_1, joystick_2, joystick_3, joystick_4;
	logic [1:0] buttons;
	logic [1:0] switches;
	logic scandoubler_disable, ypbpr, no_csync;
	status_t status;
	logic key_pressed, key_extended, key_strobe;
	byte_t key_code;
	mouse_axis_t mouse_x, mouse_y;
	mouse_wheel_t mouse_z;
	byte_t mouse_flags;
	logic mouse_idx, mouse_strobe;

	// transfer under test, byte 0 is the command
	byte_t frame [MAX_BYTES];
	int frame_len;
	logic [31:0] lfsr;
	// reference model state
	byte_t exp_but_sw;
	joystick_t exp_joy [JOY_COUNT];
	status_t exp_status;
	// pressed, extended, code
	logic [9:0] exp_key;
	// x, y, wheel, flags, index
	logic [30:0] exp_mouse;
	int errors, checks;
	int key_seen, key_want, mouse_seen, mouse_want;
	logic key_q, mouse_q;

	user_io u_dut (
		.SPI_CLK   (spi_clk),
		.SPI_SS_IO (spi_ss_io),
		.SPI_MOSI  (spi_mosi),
		.SPI_MISO  (spi_miso),
		.*
	);

	// config string RAM, address times 3 plus 7
	assign conf_chr = byte_t'(conf_addr * 10'd3 + 10'd7);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic byte_t rand_byte();
		byte_t r;
		int i;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			r[i] = lfsr[0];
		end
		return r;
	endfunction

	// MISO byte expected at position n of a transfer
	function automatic byte_t reply_ref(input byte_t cmd, input int n);
		if (n == 0)
			return CORE_TYPE;
		if (cmd == CMD_CONF_STR)
			return byte_t'((n - 1) * 3 + 7);
		return 8'h00;
	endfunction

	// button, status and joystick contents after the current transfer
	function automatic void regs_ref();
		int i;
		int j;
		j = int'(frame[0]) - int'(CMD_JOY_BASE);
		for (i = 1; i < frame_len; i++) begin
			if (frame[0] == CMD_BUT_SW)
				exp_but_sw = frame[i];
			else if (frame[0] == CMD_STATUS)
				exp_status = {56'd0, frame[i]};
			else if (frame[0] == CMD_STATUS64 && i <= 8)
				exp_status[8 * (i - 1) +: 8] = frame[i];
			else if (j >= 0 && j < JOY_COUNT && i <= 4)
				exp_joy[j][8 * (i - 1) +: 8] = frame[i];
		end
	endfunction

	// prefixes apply to the next code byte of the same transfer
	function automatic void key_ref();
		logic ext;
		logic brk;
		int i;
		ext = 1'b0;
		brk = 1'b0;
		for (i = 1; i < frame_len; i++) begin
			if (frame[i] == KEY_EXT_PREFIX) begin
				ext = 1'b1;
			end else if (frame[i] == KEY_BREAK_PREFIX) begin
				brk = 1'b1;
			end else begin
				exp_key = {!brk, ext, frame[i]};
				key_want++;
			end
		end
	endfunction

	// flags bits 4 and 5 are the X and Y signs
	function automatic void mouse_ref();
		exp_mouse = {frame[1][4], frame[2], frame[1][5], frame[3],
			frame[4][3:0], frame[1], frame[0][0]};
		mouse_want++;
	endfunction

	function automatic joystick_t dut_joy(input int j);
		case (j)
			0: return joystick_0;
			1: return joystick_1;
			2: return joystick_2;
			3: return joystick_3;
			default: return joystick_4;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, want);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic make_frame(input byte_t cmd, input int n_payload);
		int i;
		frame[0] = cmd;
		frame_len = n_payload + 1;
		for (i = 1; i <= n_payload; i++)
			frame[i] = rand_byte();
	endtask

	task automatic key_frame(input logic ext, input logic brk);
		frame[0] = CMD_KBD;
		frame_len = 1;
		if (ext) begin
			frame[frame_len] = KEY_EXT_PREFIX;
			frame_len++;
		end
		if (brk) begin
			frame[frame_len] = KEY_BREAK_PREFIX;
			frame_len++;
		end
		// codes below 0x80 never look like a prefix
		frame[frame_len] = rand_byte() & 8'h7F;
		frame_len++;
	endtask

	// one SPI transfer, SPI_CLK idles high and MOSI moves on its falling edge
	task automatic send_frame();
		byte_t got;
		int i;
		int b;
		spi_ss_io = 1'b0;
		wait_cycles(HALF_SPI);
		for (i = 0; i < frame_len; i++) begin
			for (b = 7; b >= 0; b--) begin
				spi_clk = 1'b0;
				spi_mosi = frame[i][b];
				wait_cycles(HALF_SPI);
				// MISO last moved on the falling edge
				got[b] = spi_miso;
				spi_clk = 1'b1;
				wait_cycles(HALF_SPI);
			end
			check_value($sformatf("MISO byte %0d", i), got, reply_ref(frame[0], i));
		end
		spi_ss_io = 1'b1;
		spi_mosi = 1'b0;
		wait_cycles(GAP);
		check_value("MISO while deselected", spi_miso, 64'd0);
	endtask

	task automatic run_frame();
		int j;
		j = int'(frame[0]) - int'(CMD_JOY_BASE);
		regs_ref();
		if (frame[0] == CMD_KBD)
			key_ref();
		if ((frame[0] == CMD_MOUSE0 || frame[0] == CMD_MOUSE1) && frame_len >= 5)
			mouse_ref();
		send_frame();
		if (frame[0] == CMD_BUT_SW)
			check_value("buttons, switches and video flags",
				{no_csync, ypbpr, scandoubler_disable, switches, buttons}, exp_but_sw[6:0]);
		if (frame[0] == CMD_STATUS || frame[0] == CMD_STATUS64)
			check_value("status", status, exp_status);
		if (j >= 0 && j < JOY_COUNT)
			check_value($sformatf("joystick %0d", j), dut_joy(j), exp_joy[j]);
		check_value("key strobe count", key_seen, key_want);
		check_value("mouse strobe count", mouse_seen, mouse_want);
	endtask

	// event outputs compared as each strobe fires
	always @(negedge clk_sys) begin
		if ((key_strobe && key_q) || (mouse_strobe && mouse_q)) begin
			errors++;
			$display("an event strobe stayed high for two cycles at time %0t", $time);
		end
		if (key_strobe) begin
			key_seen++;
			if ({key_pressed, key_extended, key_code} !== exp_key) begin
				errors++;
				$display("Mismatch at %0t: key event got %h expected %h", $time,
					{key_pressed, key_extended, key_code}, exp_key);
			end
		end
		if (mouse_strobe) begin
			mouse_seen++;
			if ({mouse_x, mouse_y, mouse_z, mouse_flags, mouse_idx} !== exp_mouse) begin
				errors++;
				$display("Mismatch at %0t: mouse packet got %h expected %h", $time,
					{mouse_x, mouse_y, mouse_z, mouse_flags, mouse_idx}, exp_mouse);
			end
		end
		key_q <= key_strobe;
		mouse_q <= mouse_strobe;
	end

	initial begin
		int round;
		int j;
		spi_ss_io = 1'b1;
		spi_clk = 1'b1;
		spi_mosi = 1'b0;
		lfsr = 32'h748d;
		errors = 0;
		checks = 0;
		key_seen = 0;
		key_want = 0;
		mouse_seen = 0;
		mouse_want = 0;
		key_q = 1'b0;
		mouse_q = 1'b0;
		// select held high is the reset
		wait_cycles(2);
		for (round = 0; round < ROUNDS; round++) begin
			make_frame(CMD_BUT_SW, 1);
			run_frame();
			// fifth payload byte must be ignored
			for (j = 0; j < JOY_COUNT; j++) begin
				make_frame(CMD_JOY_BASE + byte_t'(j), 5);
				run_frame();
			end
			make_frame(CMD_STATUS64, 8);
			run_frame();
			make_frame(CMD_STATUS, 1);
			run_frame();
			make_frame(CMD_CONF_STR, MAX_BYTES - 1);
			run_frame();
			key_frame(1'b0, 1'b0);
			run_frame();
			key_frame(1'b1, 1'b0);
			run_frame();
			key_frame(1'b0, 1'b1);
			run_frame();
			key_frame(1'b1, 1'b1);
			run_frame();
			make_frame(CMD_MOUSE0, 4);
			run_frame();
			make_frame(CMD_MOUSE1, 4);
			run_frame();
		end
		$display("%0d checks, %0d errors, %0d key events, %0d mouse events",
			checks, errors, key_seen, mouse_seen);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog sized from the transfer count
	initial begin
		#(TIMEOUT);
		$display("timeout after %0d time units with %0d checks and %0d errors so far",
			TIMEOUT, checks, errors);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
src/user_io_pkg.sv
src/spi_link_if.sv
src/cmd_byte_if.sv
src/spi_byte_receiver.sv
src/spi_reply_shifter.sv
src/cmd_byte_sequencer.sv
src/control_registers.sv
src/input_event_decoder.sv
src/user_io.sv
tests/user_io_properties.sv
tests/tb_user_io.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_user_io -f sim.f -o tb_user_io \
	&& ./obj_dir/tb_user_io > sim.log 2>&1
grep -q "test passed" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
